// ==== hw/dzcpuPkg.sv ====
package dzcpuPkg;

	//////////////////////////////////////////////////
	// Micro-op word {flow, operation, operand}
	localparam int FlowCtrlWidth  = 4;
	localparam int OperationWidth = 5;
	localparam int OperandWidth   = 5;
	localparam int UopWidth       = FlowCtrlWidth + OperationWidth + OperandWidth;
	localparam int UopAddrWidth   = 9;

	//////////////////////////////////////////////////
	// Flow control codes
	localparam logic [FlowCtrlWidth-1:0] FlowOp          = 4'd0;
	localparam logic [FlowCtrlWidth-1:0] FlowInc         = 4'd1;
	localparam logic [FlowCtrlWidth-1:0] FlowEof         = 4'd2;
	localparam logic [FlowCtrlWidth-1:0] FlowIncEof      = 4'd3;
	localparam logic [FlowCtrlWidth-1:0] FlowEofFu       = 4'd4;
	localparam logic [FlowCtrlWidth-1:0] FlowIncEofFu    = 4'd5;
	localparam logic [FlowCtrlWidth-1:0] FlowIncEofZ     = 4'd6;
	localparam logic [FlowCtrlWidth-1:0] FlowIncEofNz    = 4'd7;
	localparam logic [FlowCtrlWidth-1:0] FlowUpdateFlags = 4'd8;

	// Datapath operations
	localparam logic [OperationWidth-1:0] OpNop     = 5'd0;
	localparam logic [OperationWidth-1:0] OpSma     = 5'd1;
	localparam logic [OperationWidth-1:0] OpSmw     = 5'd2;
	localparam logic [OperationWidth-1:0] OpSrm     = 5'd3;
	localparam logic [OperationWidth-1:0] OpInc16   = 5'd4;
	localparam logic [OperationWidth-1:0] OpDec16   = 5'd5;
	localparam logic [OperationWidth-1:0] OpSx16r   = 5'd6;
	localparam logic [OperationWidth-1:0] OpSrx16   = 5'd7;
	localparam logic [OperationWidth-1:0] OpAddx16  = 5'd8;
	localparam logic [OperationWidth-1:0] OpSubx16  = 5'd9;
	localparam logic [OperationWidth-1:0] OpSpc     = 5'd10;
	localparam logic [OperationWidth-1:0] OpJcb     = 5'd11;
	localparam logic [OperationWidth-1:0] OpBit     = 5'd12;
	localparam logic [OperationWidth-1:0] OpShl     = 5'd13;
	localparam logic [OperationWidth-1:0] OpZ801bop = 5'd14;
	localparam logic [OperationWidth-1:0] OpCeti    = 5'd15;

	// Register operands
	localparam logic [OperandWidth-1:0] RegB    = 5'd0;
	localparam logic [OperandWidth-1:0] RegC    = 5'd1;
	localparam logic [OperandWidth-1:0] RegD    = 5'd2;
	localparam logic [OperandWidth-1:0] RegE    = 5'd3;
	localparam logic [OperandWidth-1:0] RegH    = 5'd4;
	localparam logic [OperandWidth-1:0] RegL    = 5'd5;
	localparam logic [OperandWidth-1:0] RegA    = 5'd6;
	localparam logic [OperandWidth-1:0] RegF    = 5'd7;
	localparam logic [OperandWidth-1:0] RegSp   = 5'd8;
	localparam logic [OperandWidth-1:0] RegPc   = 5'd9;
	localparam logic [OperandWidth-1:0] RegX8   = 5'd10;
	localparam logic [OperandWidth-1:0] RegX16  = 5'd11;
	localparam logic [OperandWidth-1:0] RegNull = 5'd12;

	//////////////////////////////////////////////////
	// Control store layout

	// Short flows packed at the bottom
	localparam logic [UopAddrWidth-1:0] FlowDefault   = 9'd0;
	localparam logic [UopAddrWidth-1:0] FlowNop       = 9'd2;
	localparam logic [UopAddrWidth-1:0] FlowDi        = 9'd3;
	localparam logic [UopAddrWidth-1:0] FlowCbPrefix  = 9'd4;
	localparam logic [UopAddrWidth-1:0] FlowCbBit7    = 9'd7;
	localparam logic [UopAddrWidth-1:0] FlowCbRl      = 9'd8;
	localparam logic [UopAddrWidth-1:0] FlowCbDefault = 9'd9;

	// Relative jumps on 8-word slots
	localparam logic [UopAddrWidth-1:0] FlowJrn  = 9'd16;
	localparam logic [UopAddrWidth-1:0] FlowJrnz = 9'd24;
	localparam logic [UopAddrWidth-1:0] FlowJrz  = 9'd32;

	// Per-register flows sit on aligned rows, the low address bits pick the register
	localparam logic [UopAddrWidth-1:0] FlowIncBase  = 9'd40;
	localparam logic [UopAddrWidth-1:0] FlowDecBase  = 9'd48;
	localparam logic [UopAddrWidth-1:0] FlowLdBase   = 9'd64;
	localparam logic [UopAddrWidth-1:0] FlowAddBase  = 9'd96;
	localparam logic [UopAddrWidth-1:0] FlowSubBase  = 9'd128;
	localparam logic [UopAddrWidth-1:0] FlowPushBase = 9'd160;
	localparam logic [UopAddrWidth-1:0] FlowPopBase  = 9'd192;

	// Last word of POP AF
	localparam logic [UopAddrWidth-1:0] LastUopAddr = 9'd221;

endpackage

// ==== hw/mopDispatch.sv ====
`timescale 1ns/1ps

module mopDispatch
(
	input  logic [7:0]                         mop,
	input  logic [7:0]                         cbByte,
	output logic [dzcpuPkg::UopAddrWidth-1:0]  flowStart,
	output logic [dzcpuPkg::UopAddrWidth-1:0]  cbFlowStart
);

	// Main opcode table
	always_comb
	begin
		case (mop)
			8'h00: flowStart = dzcpuPkg::FlowNop;
			8'hF3: flowStart = dzcpuPkg::FlowDi;
			8'hCB: flowStart = dzcpuPkg::FlowCbPrefix;
			8'h18: flowStart = dzcpuPkg::FlowJrn;
			8'h20: flowStart = dzcpuPkg::FlowJrnz;
			8'h28: flowStart = dzcpuPkg::FlowJrz;
			// INC r, one word per register
			8'h04: flowStart = dzcpuPkg::FlowIncBase;
			8'h0C: flowStart = dzcpuPkg::FlowIncBase + 9'd1;
			8'h14: flowStart = dzcpuPkg::FlowIncBase + 9'd2;
			8'h1C: flowStart = dzcpuPkg::FlowIncBase + 9'd3;
			8'h24: flowStart = dzcpuPkg::FlowIncBase + 9'd4;
			8'h2C: flowStart = dzcpuPkg::FlowIncBase + 9'd5;
			8'h3C: flowStart = dzcpuPkg::FlowIncBase + 9'd6;
			// DEC r
			8'h05: flowStart = dzcpuPkg::FlowDecBase;
			8'h0D: flowStart = dzcpuPkg::FlowDecBase + 9'd1;
			8'h15: flowStart = dzcpuPkg::FlowDecBase + 9'd2;
			8'h1D: flowStart = dzcpuPkg::FlowDecBase + 9'd3;
			8'h25: flowStart = dzcpuPkg::FlowDecBase + 9'd4;
			8'h2D: flowStart = dzcpuPkg::FlowDecBase + 9'd5;
			8'h3D: flowStart = dzcpuPkg::FlowDecBase + 9'd6;
			// LD r,n on 4-word rows
			8'h06: flowStart = dzcpuPkg::FlowLdBase;
			8'h0E: flowStart = dzcpuPkg::FlowLdBase + 9'd4;
			8'h16: flowStart = dzcpuPkg::FlowLdBase + 9'd8;
			8'h1E: flowStart = dzcpuPkg::FlowLdBase + 9'd12;
			8'h26: flowStart = dzcpuPkg::FlowLdBase + 9'd16;
			8'h2E: flowStart = dzcpuPkg::FlowLdBase + 9'd20;
			8'h3E: flowStart = dzcpuPkg::FlowLdBase + 9'd24;
			// ADD A,r
			8'h80: flowStart = dzcpuPkg::FlowAddBase;
			8'h81: flowStart = dzcpuPkg::FlowAddBase + 9'd4;
			8'h82: flowStart = dzcpuPkg::FlowAddBase + 9'd8;
			8'h83: flowStart = dzcpuPkg::FlowAddBase + 9'd12;
			8'h84: flowStart = dzcpuPkg::FlowAddBase + 9'd16;
			8'h85: flowStart = dzcpuPkg::FlowAddBase + 9'd20;
			8'h87: flowStart = dzcpuPkg::FlowAddBase + 9'd24;
			// SUB r
			8'h90: flowStart = dzcpuPkg::FlowSubBase;
			8'h91: flowStart = dzcpuPkg::FlowSubBase + 9'd4;
			8'h92: flowStart = dzcpuPkg::FlowSubBase + 9'd8;
			8'h93: flowStart = dzcpuPkg::FlowSubBase + 9'd12;
			8'h94: flowStart = dzcpuPkg::FlowSubBase + 9'd16;
			8'h95: flowStart = dzcpuPkg::FlowSubBase + 9'd20;
			8'h97: flowStart = dzcpuPkg::FlowSubBase + 9'd24;
			// Stack pairs BC, DE, HL, AF on 8-word rows
			8'hC5: flowStart = dzcpuPkg::FlowPushBase;
			8'hD5: flowStart = dzcpuPkg::FlowPushBase + 9'd8;
			8'hE5: flowStart = dzcpuPkg::FlowPushBase + 9'd16;
			8'hF5: flowStart = dzcpuPkg::FlowPushBase + 9'd24;
			8'hC1: flowStart = dzcpuPkg::FlowPopBase;
			8'hD1: flowStart = dzcpuPkg::FlowPopBase + 9'd8;
			8'hE1: flowStart = dzcpuPkg::FlowPopBase + 9'd16;
			8'hF1: flowStart = dzcpuPkg::FlowPopBase + 9'd24;
			default: flowStart = dzcpuPkg::FlowDefault;
		endcase
	end

	// Second byte after the CB prefix
	always_comb
	begin
		case (cbByte)
			8'h7C: cbFlowStart = dzcpuPkg::FlowCbBit7;
			8'h11: cbFlowStart = dzcpuPkg::FlowCbRl;
			default: cbFlowStart = dzcpuPkg::FlowCbDefault;
		endcase
	end

endmodule

// ==== hw/ucodeRom.sv ====
`timescale 1ns/1ps

module ucodeRom
(
	input  logic [dzcpuPkg::UopAddrWidth-1:0]  uopAddr,
	output logic [dzcpuPkg::UopWidth-1:0]      uop
);

	localparam logic [dzcpuPkg::UopWidth-1:0] NopStep =
		{dzcpuPkg::FlowOp, dzcpuPkg::OpNop, dzcpuPkg::RegNull};

	logic [dzcpuPkg::OperandWidth-1:0]   slotReg;
	logic [dzcpuPkg::OperandWidth-1:0]   rowReg;
	logic [dzcpuPkg::OperandWidth-1:0]   pairHigh;
	logic [dzcpuPkg::OperandWidth-1:0]   pairLow;
	logic [dzcpuPkg::FlowCtrlWidth-1:0]  jrCond;

	// Register index in opcode order, index 7 is F so that pair 3 reads AF
	function automatic logic [dzcpuPkg::OperandWidth-1:0] regOf(input logic [2:0] idx);
		case (idx)
			3'd0: regOf = dzcpuPkg::RegB;
			3'd1: regOf = dzcpuPkg::RegC;
			3'd2: regOf = dzcpuPkg::RegD;
			3'd3: regOf = dzcpuPkg::RegE;
			3'd4: regOf = dzcpuPkg::RegH;
			3'd5: regOf = dzcpuPkg::RegL;
			3'd6: regOf = dzcpuPkg::RegA;
			default: regOf = dzcpuPkg::RegF;
		endcase
	endfunction

	assign slotReg  = regOf(uopAddr[2:0]);
	assign rowReg   = regOf(uopAddr[4:2]);
	assign pairHigh = regOf({uopAddr[4:3], 1'b0});
	assign pairLow  = regOf({uopAddr[4:3], 1'b1});

	// Only the conditional jumps may leave at the offset fetch
	assign jrCond = (uopAddr == dzcpuPkg::FlowJrnz + 9'd2) ? dzcpuPkg::FlowIncEofZ :
	                (uopAddr == dzcpuPkg::FlowJrz + 9'd2)  ? dzcpuPkg::FlowIncEofNz :
	                                                         dzcpuPkg::FlowInc;

	always_comb
	begin
		case (uopAddr) inside
			//////////////////////////////////////////////////
			// Single byte flows
			dzcpuPkg::FlowDefault:
				uop = {dzcpuPkg::FlowUpdateFlags, dzcpuPkg::OpZ801bop, dzcpuPkg::RegA};
			dzcpuPkg::FlowDefault + 9'd1:
				uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpNop, dzcpuPkg::RegNull};
			dzcpuPkg::FlowNop:
				uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpNop, dzcpuPkg::RegNull};
			dzcpuPkg::FlowDi:
				uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpCeti, dzcpuPkg::RegNull};

			//////////////////////////////////////////////////
			// CB prefix, the jcb word jumps on the second byte
			dzcpuPkg::FlowCbPrefix:
				uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpSma, dzcpuPkg::RegPc};
			dzcpuPkg::FlowCbPrefix + 9'd1:
				uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpNop, dzcpuPkg::RegNull};
			dzcpuPkg::FlowCbPrefix + 9'd2:
				uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpJcb, dzcpuPkg::RegNull};
			dzcpuPkg::FlowCbBit7:
				uop = {dzcpuPkg::FlowEofFu, dzcpuPkg::OpBit, dzcpuPkg::RegNull};
			dzcpuPkg::FlowCbRl:
				uop = {dzcpuPkg::FlowEofFu, dzcpuPkg::OpShl, dzcpuPkg::RegNull};
			dzcpuPkg::FlowCbDefault:
				uop = {dzcpuPkg::FlowEofFu, dzcpuPkg::OpZ801bop, dzcpuPkg::RegNull};

			//////////////////////////////////////////////////
			// JR n, JR NZ, JR Z
			[dzcpuPkg::FlowJrn : dzcpuPkg::FlowJrz + 9'd5]:
				case (uopAddr[2:0])
					3'd0: uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpSma, dzcpuPkg::RegPc};
					3'd1: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpNop, dzcpuPkg::RegNull};
					3'd2: uop = {jrCond, dzcpuPkg::OpSrm, dzcpuPkg::RegX8};
					3'd3: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSx16r, dzcpuPkg::RegPc};
					3'd4: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpAddx16, dzcpuPkg::RegX8};
					3'd5: uop = {dzcpuPkg::FlowEof, dzcpuPkg::OpSpc, dzcpuPkg::RegX16};
					default: uop = NopStep;
				endcase

			//////////////////////////////////////////////////
			// Register flows
			[dzcpuPkg::FlowIncBase : dzcpuPkg::FlowIncBase + 9'd6]:
				uop = {dzcpuPkg::FlowIncEofFu, dzcpuPkg::OpInc16, slotReg};
			[dzcpuPkg::FlowDecBase : dzcpuPkg::FlowDecBase + 9'd6]:
				uop = {dzcpuPkg::FlowIncEofFu, dzcpuPkg::OpDec16, slotReg};
			[dzcpuPkg::FlowLdBase : dzcpuPkg::FlowLdBase + 9'd27]:
				case (uopAddr[1:0])
					2'd0: uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpSma, dzcpuPkg::RegPc};
					2'd1: uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpNop, dzcpuPkg::RegNull};
					2'd2: uop = {dzcpuPkg::FlowEof, dzcpuPkg::OpSrm, rowReg};
					default: uop = NopStep;
				endcase
			[dzcpuPkg::FlowAddBase : dzcpuPkg::FlowAddBase + 9'd27]:
				case (uopAddr[1:0])
					2'd0: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSx16r, dzcpuPkg::RegA};
					2'd1: uop = {dzcpuPkg::FlowUpdateFlags, dzcpuPkg::OpAddx16, rowReg};
					2'd2: uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpSrx16, dzcpuPkg::RegA};
					default: uop = NopStep;
				endcase
			[dzcpuPkg::FlowSubBase : dzcpuPkg::FlowSubBase + 9'd27]:
				case (uopAddr[1:0])
					2'd0: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSx16r, dzcpuPkg::RegA};
					2'd1: uop = {dzcpuPkg::FlowUpdateFlags, dzcpuPkg::OpSubx16, rowReg};
					2'd2: uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpSrx16, dzcpuPkg::RegA};
					default: uop = NopStep;
				endcase

			//////////////////////////////////////////////////
			// Stack flows, high byte pushed first
			[dzcpuPkg::FlowPushBase : dzcpuPkg::FlowPushBase + 9'd29]:
				case (uopAddr[2:0])
					3'd0: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpDec16, dzcpuPkg::RegSp};
					3'd1: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSma, dzcpuPkg::RegSp};
					3'd2: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSmw, pairHigh};
					3'd3: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpDec16, dzcpuPkg::RegSp};
					3'd4: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSmw, pairLow};
					3'd5: uop = {dzcpuPkg::FlowIncEof, dzcpuPkg::OpSma, dzcpuPkg::RegPc};
					default: uop = NopStep;
				endcase
			[dzcpuPkg::FlowPopBase : dzcpuPkg::LastUopAddr]:
				case (uopAddr[2:0])
					3'd0: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSma, dzcpuPkg::RegSp};
					3'd1: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpInc16, dzcpuPkg::RegSp};
					3'd2: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSrm, pairLow};
					3'd3: uop = {dzcpuPkg::FlowOp, dzcpuPkg::OpSrm, pairHigh};
					3'd4: uop = {dzcpuPkg::FlowInc, dzcpuPkg::OpInc16, dzcpuPkg::RegSp};
					3'd5: uop = {dzcpuPkg::FlowEof, dzcpuPkg::OpSma, dzcpuPkg::RegPc};
					default: uop = NopStep;
				endcase
			default: uop = NopStep;
		endcase
	end

	// Any address the sequencer settles on stays inside the table
	assert property (@(uopAddr)
		!$isunknown(uopAddr) |-> uopAddr <= dzcpuPkg::LastUopAddr);

endmodule

// ==== hw/microSequencer.sv ====
`timescale 1ns/1ps

module microSequencer
(
	input  logic                                 Clock,
	input  logic                                 reset,
	input  logic [dzcpuPkg::UopWidth-1:0]        uop,
	input  logic                                 zeroFlag,
	input  logic [dzcpuPkg::UopAddrWidth-1:0]    flowStart,
	input  logic [dzcpuPkg::UopAddrWidth-1:0]    cbFlowStart,
	output logic [dzcpuPkg::UopAddrWidth-1:0]    uopAddr,
	output logic                                 fetch,
	output logic                                 uopValid,
	output logic                                 pcInc,
	output logic                                 flagUpdate,
	output logic                                 endFlow,
	output logic [dzcpuPkg::OperationWidth-1:0]  operation,
	output logic [dzcpuPkg::OperandWidth-1:0]    operand
);

	logic                                running;
	logic [dzcpuPkg::FlowCtrlWidth-1:0]  flowCtrl;
	logic                                incCode;
	logic                                fuCode;
	logic                                eofCode;

	// Split the word into its fields
	assign flowCtrl  = uop[dzcpuPkg::UopWidth-1 -: dzcpuPkg::FlowCtrlWidth];
	assign operation = uop[dzcpuPkg::OperandWidth +: dzcpuPkg::OperationWidth];
	assign operand   = uop[dzcpuPkg::OperandWidth-1:0];

	// Dispatch cycle whenever no flow is running
	assign fetch    = !running;
	assign uopValid = running;

	//////////////////////////////////////////////////
	// Flow code decode
	always_comb
	begin
		incCode = 1'b0;
		fuCode  = 1'b0;
		eofCode = 1'b0;
		case (flowCtrl)
			dzcpuPkg::FlowInc:
				incCode = 1'b1;
			dzcpuPkg::FlowEof:
				eofCode = 1'b1;
			dzcpuPkg::FlowIncEof:
			begin
				incCode = 1'b1;
				eofCode = 1'b1;
			end
			dzcpuPkg::FlowEofFu:
			begin
				fuCode  = 1'b1;
				eofCode = 1'b1;
			end
			dzcpuPkg::FlowIncEofFu:
			begin
				incCode = 1'b1;
				fuCode  = 1'b1;
				eofCode = 1'b1;
			end
			// Conditional end uses the flag of this very cycle
			dzcpuPkg::FlowIncEofZ:
			begin
				incCode = 1'b1;
				eofCode = zeroFlag;
			end
			dzcpuPkg::FlowIncEofNz:
			begin
				incCode = 1'b1;
				eofCode = !zeroFlag;
			end
			dzcpuPkg::FlowUpdateFlags:
				fuCode = 1'b1;
			default: ;
		endcase
	end

	assign pcInc      = running && incCode;
	assign flagUpdate = running && fuCode;
	assign endFlow    = running && eofCode;

	//////////////////////////////////////////////////
	// Micro-program counter
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			running <= 1'b0;
			uopAddr <= dzcpuPkg::FlowDefault;
		end
		else if (!running)
		begin
			running <= 1'b1;
			uopAddr <= flowStart;
		end
		else if (endFlow)
			running <= 1'b0;    // address holds on the last word
		else if (operation == dzcpuPkg::OpJcb)
			uopAddr <= cbFlowStart;
		else
			uopAddr <= uopAddr + 1'b1;
	end

	// A jcb word must not end its flow or the CB jump is lost
	assert property (@(posedge Clock) disable iff (reset)
		(uopValid && operation == dzcpuPkg::OpJcb) |-> !endFlow);

	// Every finished flow hands over to dispatch
	assert property (@(posedge Clock) disable iff (reset)
		endFlow |=> fetch);

endmodule

// ==== hw/ucodeController.sv ====
`timescale 1ns/1ps

module ucodeController
(
	input  logic                                 Clock,
	input  logic                                 reset,
	input  logic [7:0]                           mop,
	input  logic                                 zeroFlag,
	output logic                                 fetch,
	output logic                                 uopValid,
	output logic [dzcpuPkg::OperationWidth-1:0]  operation,
	output logic [dzcpuPkg::OperandWidth-1:0]    operand,
	output logic                                 pcInc,
	output logic                                 flagUpdate,
	output logic                                 endFlow
);

	logic [dzcpuPkg::UopAddrWidth-1:0]  flowStart;
	logic [dzcpuPkg::UopAddrWidth-1:0]  cbFlowStart;
	logic [dzcpuPkg::UopAddrWidth-1:0]  uopAddr;
	logic [dzcpuPkg::UopWidth-1:0]      uop;

	// The bus byte is the opcode at dispatch and the CB byte at jcb
	mopDispatch dispatch
	(
		.mop         (mop),
		.cbByte      (mop),
		.flowStart   (flowStart),
		.cbFlowStart (cbFlowStart)
	);

	ucodeRom rom
	(
		.uopAddr (uopAddr),
		.uop     (uop)
	);

	microSequencer sequencer
	(
		.Clock       (Clock),
		.reset       (reset),
		.uop         (uop),
		.zeroFlag    (zeroFlag),
		.flowStart   (flowStart),
		.cbFlowStart (cbFlowStart),
		.uopAddr     (uopAddr),
		.fetch       (fetch),
		.uopValid    (uopValid),
		.pcInc       (pcInc),
		.flagUpdate  (flagUpdate),
		.endFlow     (endFlow),
		.operation   (operation),
		.operand     (operand)
	);

endmodule

// ==== test/ucodeChecker.sv ====
`timescale 1ns/1ps

module ucodeChecker
(
	input  logic                                 Clock,
	input  logic                                 reset,
	input  logic [7:0]                           mop,
	input  logic                                 zeroFlag,
	input  logic                                 fetch,
	input  logic                                 uopValid,
	input  logic [dzcpuPkg::OperationWidth-1:0]  operation,
	input  logic [dzcpuPkg::OperandWidth-1:0]    operand,
	input  logic                                 pcInc,
	input  logic                                 flagUpdate,
	input  logic                                 endFlow,
	output int                                   instrCount,
	output int                                   errorCount
);

	logic [7:0]                           opcode;
	logic [7:0]                           cbByte;
	logic                                 active;
	logic                                 afterReset;
	logic                                 lastEnd;
	int                                   pos;
	int                                   incCount;
	int                                   fuCount;
	int                                   expLen;
	int                                   expInc;
	int                                   expFu;
	int                                   markPos;
	logic [dzcpuPkg::OperationWidth-1:0]  markOp;
	logic [dzcpuPkg::OperandWidth-1:0]    markReg;
	logic                                 markHasReg;

	initial
	begin
		instrCount = 0;
		errorCount = 0;
		active     = 1'b0;
		afterReset = 1'b0;
		lastEnd    = 1'b0;
	end

	task automatic reportError(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		errorCount++;
	endtask

	// Register field order of the opcode, index 6 is (HL)
	function automatic logic [dzcpuPkg::OperandWidth-1:0] regFromIndex(input logic [2:0] idx);
		case (idx)
			3'd0: return dzcpuPkg::RegB;
			3'd1: return dzcpuPkg::RegC;
			3'd2: return dzcpuPkg::RegD;
			3'd3: return dzcpuPkg::RegE;
			3'd4: return dzcpuPkg::RegH;
			3'd5: return dzcpuPkg::RegL;
			default: return dzcpuPkg::RegA;
		endcase
	endfunction

	task automatic setCounts(input int len, input int inc, input int fu);
		expLen = len;
		expInc = inc;
		expFu  = fu;
	endtask

	task automatic setMark(input int p, input logic [4:0] op, input logic hasReg);
		markPos    = p;
		markOp     = op;
		markHasReg = hasReg;
	endtask

	//////////////////////////////////////////////////
	// Expected flow shape per opcode
	task automatic expectFlow(input logic [7:0] op);
		logic [2:0] hi;
		logic [2:0] lo;
		hi = op[5:3];
		lo = op[2:0];
		markReg = regFromIndex(hi);
		setCounts(2, 1, 1);
		setMark(-1, dzcpuPkg::OpNop, 1'b0);
		if (op == 8'h00 || op == 8'hF3)
		begin
			setCounts(1, 1, 0);
			if (op == 8'hF3)
				setMark(0, dzcpuPkg::OpCeti, 1'b0);
		end
		else if (op[7:6] == 2'b00 && (lo == 3'd4 || lo == 3'd5) && hi != 3'd6)
		begin
			setCounts(1, 1, 1);
			setMark(0, (lo == 3'd4) ? dzcpuPkg::OpInc16 : dzcpuPkg::OpDec16, 1'b1);
		end
		else if (op[7:6] == 2'b00 && lo == 3'd6 && hi != 3'd6)
		begin
			setCounts(3, 2, 0);
			setMark(2, dzcpuPkg::OpSrm, 1'b1);
		end
		else if ((op[7:3] == 5'h10 || op[7:3] == 5'h12) && lo != 3'd6)
		begin
			setCounts(3, 1, 1);
			setMark(1, op[4] ? dzcpuPkg::OpSubx16 : dzcpuPkg::OpAddx16, 1'b1);
			markReg = regFromIndex(lo);
		end
		else if (op[7:6] == 2'b11 && (op[3:0] == 4'h1 || op[3:0] == 4'h5))
			setCounts(6, 1, 0);
		// Conditional jumps get their length in the third micro-op
		else if (op == 8'h18 || op == 8'h20 || op == 8'h28)
			setCounts(6, 2, 0);
		else if (op == 8'hCB)
		begin
			setCounts(4, 2, 1);
			setMark(2, dzcpuPkg::OpJcb, 1'b0);
		end
	endtask

	task automatic checkUop();
		logic [dzcpuPkg::OperationWidth-1:0] cbOp;
		if (pcInc)
			incCount++;
		if (flagUpdate)
			fuCount++;
		if (pos == markPos && operation != markOp)
			reportError($sformatf("opcode %h uop %0d has operation %0d, expected %0d",
				opcode, pos, operation, markOp));
		if (pos == markPos && markHasReg && operand != markReg)
			reportError($sformatf("opcode %h uop %0d has operand %0d, expected %0d",
				opcode, pos, operand, markReg));
		if (pos == 2 && (opcode == 8'h20 || opcode == 8'h28))
			expLen = (zeroFlag == (opcode == 8'h20)) ? 3 : 6;
		if (pos == 2 && opcode == 8'hCB)
			cbByte = mop;
		cbOp = (cbByte == 8'h7C) ? dzcpuPkg::OpBit :
		       (cbByte == 8'h11) ? dzcpuPkg::OpShl : dzcpuPkg::OpZ801bop;
		if (pos == 3 && opcode == 8'hCB && operation != cbOp)
			reportError($sformatf("CB byte %h ran operation %0d, expected %0d",
				cbByte, operation, cbOp));
		if (endFlow)
		begin
			if (pos + 1 != expLen || incCount != expInc || fuCount != expFu)
				reportError($sformatf("opcode %h ran %0d/%0d/%0d uops/pcInc/flagUpdate, expected %0d/%0d/%0d",
					opcode, pos + 1, incCount, fuCount, expLen, expInc, expFu));
			instrCount++;
			active = 1'b0;
		end
		else if (pos + 1 == expLen)
			reportError($sformatf("opcode %h did not end after %0d uops", opcode, expLen));
		pos++;
	endtask

	// Sampled mid-cycle where inputs and strobes are settled
	always @(negedge Clock)
	begin
		if (reset)
		begin
			if (uopValid || pcInc || flagUpdate || endFlow)
				reportError("strobe high during reset");
			active     = 1'b0;
			afterReset = 1'b1;
			lastEnd    = 1'b0;
		end
		else
		begin
			if (fetch && uopValid)
				reportError("fetch and uopValid high together");
			if ((afterReset || lastEnd) && !fetch)
				reportError("no dispatch cycle after reset or endFlow");
			afterReset = 1'b0;
			lastEnd    = endFlow;
			if (fetch)
			begin
				opcode   = mop;
				pos      = 0;
				incCount = 0;
				fuCount  = 0;
				active   = 1'b1;
				expectFlow(mop);
			end
			else if (uopValid && active)
				checkUop();
			else if (uopValid)
				reportError("micro-op issued outside an instruction");
		end
	end

endmodule

// ==== test/ucodeControllerTb.sv ====
`timescale 1ns/1ps

module ucodeControllerTb;

	localparam int InstrTarget   = 2000;
	localparam int TimeoutCycles = 20000;

	logic                                 Clock;
	logic                                 reset;
	logic [7:0]                           mop;
	logic                                 zeroFlag;
	logic                                 fetch;
	logic                                 uopValid;
	logic [dzcpuPkg::OperationWidth-1:0]  operation;
	logic [dzcpuPkg::OperandWidth-1:0]    operand;
	logic                                 pcInc;
	logic                                 flagUpdate;
	logic                                 endFlow;
	int                                   instrCount;
	int                                   errorCount;
	int                                   cycles;
	int                                   cbWait;
	logic [31:0]                          rngState;

	// NOP DI CB JR, then INC DEC LD ADD SUB, then PUSH POP
	logic [7:0] keptOps [0:31] = '{
		8'h00, 8'hF3, 8'hCB, 8'hCB, 8'h18, 8'h20, 8'h28, 8'h20,
		8'h04, 8'h1C, 8'h3C, 8'h0D, 8'h25, 8'h3D, 8'h06, 8'h16,
		8'h2E, 8'h3E, 8'h80, 8'h84, 8'h87, 8'h91, 8'h95, 8'h97,
		8'hC5, 8'hD5, 8'hE5, 8'hF5, 8'hC1, 8'hD1, 8'hE1, 8'hF1
	};

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	ucodeController uut
	(
		.Clock      (Clock),
		.reset      (reset),
		.mop        (mop),
		.zeroFlag   (zeroFlag),
		.fetch      (fetch),
		.uopValid   (uopValid),
		.operation  (operation),
		.operand    (operand),
		.pcInc      (pcInc),
		.flagUpdate (flagUpdate),
		.endFlow    (endFlow)
	);

	ucodeChecker scoreboard
	(
		.Clock      (Clock),
		.reset      (reset),
		.mop        (mop),
		.zeroFlag   (zeroFlag),
		.fetch      (fetch),
		.uopValid   (uopValid),
		.operation  (operation),
		.operand    (operand),
		.pcInc      (pcInc),
		.flagUpdate (flagUpdate),
		.endFlow    (endFlow),
		.instrCount (instrCount),
		.errorCount (errorCount)
	);

	initial
	begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;
	end

	//////////////////////////////////////////////////
	// Stimulus, the CB byte lands in the third prefix cycle
	always @(posedge Clock)
	begin
		rngState = xorshift(rngState);
		if (fetch && mop == 8'hCB)
			cbWait = 3;
		else if (cbWait > 0)
			cbWait--;
		if (cbWait == 1)
			mop <= (rngState[1:0] != 2'd0) ? (rngState[2] ? 8'h7C : 8'h11) : rngState[15:8];
		else
			mop <= (rngState[1:0] != 2'd0) ? keptOps[rngState[7:3]] : rngState[15:8];
		zeroFlag <= rngState[16];
	end

	initial
	begin
		reset    = 1'b1;
		mop      = 8'h00;
		zeroFlag = 1'b0;
		rngState = 32'h8f6a;
		cbWait   = 0;
		cycles   = 0;
		repeat (2) @(posedge Clock);
		reset <= 1'b0;
		while (instrCount < InstrTarget && cycles < TimeoutCycles)
		begin
			@(posedge Clock);
			cycles++;
		end
		if (instrCount < InstrTarget)
		begin
			$display("Timeout after %0d cycles, %0d of %0d instructions done, errors %0d",
				cycles, instrCount, InstrTarget, errorCount);
			$display("SIMULATION FAILED");
		end
		else
		begin
			$display("Instructions %0d, errors %0d", instrCount, errorCount);
			if (errorCount == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== ucodeController.f ====
hw/dzcpuPkg.sv
hw/mopDispatch.sv
hw/ucodeRom.sv
hw/microSequencer.sv
hw/ucodeController.sv
test/ucodeChecker.sv
test/ucodeControllerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ucodeControllerTb
FILELIST  ?= ucodeController.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
